/* all.f */
+incdir+source
+incdir+testbench
source/csr_cmd_pkg.sv
source/csr_map_pkg.sv
source/spi_trx.sv
source/csr_regs.sv
source/csr_sequencer.sv
source/csr_spi.sv
testbench/tb_csr_spi.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_csr_spi -f all.f \
    -o tb_csr_spi > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "BUILD FAILED, see build.log"
    exit 1
fi

./obj_dir/tb_csr_spi > sim.log 2>&1
run_status=$?

if grep -qx "sim passed" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL (simulator status $run_status), see sim.log"
exit 1

/* source/csr_cmd_pkg.sv */
`default_nettype none

package csr_cmd_pkg;

    typedef enum logic [1:0] {
        REP_0,
        REP_1,
        REP_4,
        REP_16
    } rep_code_t;

    typedef struct packed {
        logic      we;        // Write enable
        rep_code_t rep;
        logic      prom;      // 1 selects program ROM
        logic [3:0] addr_hi;
    } cmd_byte_t;

    function automatic logic [4:0] rep_count(rep_code_t code);
        case (code)
            REP_0:   rep_count = 5'd0;
            REP_1:   rep_count = 5'd1;
            REP_4:   rep_count = 5'd4;
            default: rep_count = 5'd16;
        endcase
    endfunction

    localparam logic [7:0] RSP_NOP            = 8'h90;
    localparam logic [7:0] RSP_SPECIAL        = 8'h91;
    localparam logic [7:0] RSP_CSR            = 8'hCC;
    localparam logic [7:0] RSP_CSR_ADDR       = 8'hAD;
    localparam logic [7:0] RSP_PROM           = 8'hCA;
    localparam logic [7:0] RSP_PROM_MID       = 8'hA0;
    localparam logic [7:0] RSP_PROM_LOW       = 8'hA1;
    localparam logic [7:0] RSP_DRAM_CMD       = 8'hC0;
    localparam logic [7:0] RSP_PROM_DATA_BASE = 8'hD0; // Low bits carry byte offset
    localparam logic [7:0] RSP_DRAM_ADDR_BASE = 8'hA0; // Low bits carry bytes left

endpackage

`default_nettype wire

/* source/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Audio channels, each with a 32-bit volume word
`define CSR_NUM_CH 8

// S/PDIF receivers feeding the rate detectors
`define CSR_NUM_SPDIF_IN 3

// Bits in one detected rate code
`define CSR_NUM_RATE 5

// Bytes in each DSP debug mailbox
`define CSR_DBG_BYTES 16

// DRAM word address width
`define CSR_DRAM_AW 28

`endif

/* source/csr_map_pkg.sv */
`default_nettype none

package csr_map_pkg;

    typedef logic [11:0] csr_addr_t;

    // Four bytes per channel, MSB at the lowest address
    localparam csr_addr_t VOL_BASE      = 12'h000;

    localparam csr_addr_t NKMD_RST_ADDR = 12'h400; // Bit 0 holds DSP in reset

    localparam csr_addr_t DBGIN_BASE    = 12'h500; // Host to DSP mailbox
    localparam csr_addr_t DBGOUT_BASE   = 12'h600; // DSP to host, read only

    // One byte per S/PDIF input
    localparam csr_addr_t RATE_BASE     = 12'h800;

endpackage

`default_nettype wire

/* source/csr_regs.sv */
`timescale 1ns/10ps
`include "csr_defines.svh"
`default_nettype none

module csr_regs (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  csr_map_pkg::csr_addr_t               reg_addr_i,
    input  wire                                        reg_we_i,
    input  wire  [7:0]                                 reg_wdata_i,
    input  wire  [`CSR_DBG_BYTES*8-1:0]                dbgout_i,
    input  wire  [`CSR_NUM_SPDIF_IN*`CSR_NUM_RATE-1:0] rate_i,
    output logic [7:0]                                 reg_rdata_o,
    output logic [`CSR_NUM_CH*32-1:0]                  vol_o,
    output logic                                       nkmd_rst_o,
    output logic [`CSR_DBG_BYTES*8-1:0]                dbgin_o
);

    import csr_map_pkg::*;

    localparam int VOL_BYTES = `CSR_NUM_CH * 4;
    localparam int VOL_IW    = $clog2(VOL_BYTES);
    localparam int DBG_IW    = $clog2(`CSR_DBG_BYTES);
    localparam int RATE_IW   = $clog2(`CSR_NUM_SPDIF_IN);

    logic [7:0] vol_mem [VOL_BYTES];
    logic [7:0] dbgin_mem [`CSR_DBG_BYTES];
    csr_addr_t  vol_off;
    csr_addr_t  dbgin_off;
    csr_addr_t  dbgout_off;
    csr_addr_t  rate_off;
    logic       vol_hit;
    logic       nkmd_hit;
    logic       dbgin_hit;
    logic       dbgout_hit;
    logic       rate_hit;

    // Offsets wrap below the base, so a single compare decodes each window
    assign vol_off    = reg_addr_i - VOL_BASE;
    assign dbgin_off  = reg_addr_i - DBGIN_BASE;
    assign dbgout_off = reg_addr_i - DBGOUT_BASE;
    assign rate_off   = reg_addr_i - RATE_BASE;

    assign vol_hit    = vol_off < VOL_BYTES;
    assign nkmd_hit   = reg_addr_i == NKMD_RST_ADDR;
    assign dbgin_hit  = dbgin_off < `CSR_DBG_BYTES;
    assign dbgout_hit = dbgout_off < `CSR_DBG_BYTES;
    assign rate_hit   = rate_off < `CSR_NUM_SPDIF_IN;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < VOL_BYTES; i++) begin
                vol_mem[i] <= 8'h00;
            end
            for (int i = 0; i < `CSR_DBG_BYTES; i++) begin
                dbgin_mem[i] <= 8'h00;
            end
            nkmd_rst_o <= 1'b0;
        end else if (reg_we_i) begin
            if (vol_hit) begin
                vol_mem[vol_off[VOL_IW-1:0]] <= reg_wdata_i;
            end
            if (dbgin_hit) begin
                dbgin_mem[dbgin_off[DBG_IW-1:0]] <= reg_wdata_i;
            end
            if (nkmd_hit) begin
                nkmd_rst_o <= reg_wdata_i[0];
            end
        end
    end

    always_comb begin
        reg_rdata_o = 8'h00; // Unmapped
        if (vol_hit) begin
            reg_rdata_o = vol_mem[vol_off[VOL_IW-1:0]];
        end else if (nkmd_hit) begin
            reg_rdata_o = {7'd0, nkmd_rst_o};
        end else if (dbgin_hit) begin
            reg_rdata_o = dbgin_mem[dbgin_off[DBG_IW-1:0]];
        end else if (dbgout_hit) begin
            reg_rdata_o = dbgout_i[8*dbgout_off[DBG_IW-1:0] +: 8];
        end else if (rate_hit) begin
            reg_rdata_o = {{(8-`CSR_NUM_RATE){1'b0}},
                           rate_i[`CSR_NUM_RATE*rate_off[RATE_IW-1:0] +: `CSR_NUM_RATE]};
        end
    end

    always_comb begin
        for (int ch = 0; ch < `CSR_NUM_CH; ch++) begin
            vol_o[32*ch +: 32] = {vol_mem[4*ch], vol_mem[4*ch+1],
                                  vol_mem[4*ch+2], vol_mem[4*ch+3]};
        end
        for (int i = 0; i < `CSR_DBG_BYTES; i++) begin
            dbgin_o[8*i +: 8] = dbgin_mem[i];
        end
    end

endmodule

`default_nettype wire

/* source/csr_sequencer.sv */
`timescale 1ns/10ps
`include "csr_defines.svh"
`default_nettype none

module csr_sequencer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [7:0]                   rx_data_i,
    input  wire                          rx_pop_i,
    input  wire                          ss_idle_i,
    output logic [7:0]                   tx_data_o,
    output logic                         tx_load_o,
    output wire  csr_map_pkg::csr_addr_t reg_addr_o,
    output wire                          reg_we_o,
    input  wire  [7:0]                   reg_rdata_i,
    output wire  [19:0]                  prom_addr_o,
    output wire  [31:0]                  prom_wdata_o,
    output wire                          prom_we_o,
    output wire  [`CSR_DRAM_AW-1:0]      dram_addr_o,
    output wire  [31:0]                  dram_wdata_o,
    output wire                          dram_pop_o,
    output wire                          dram_we_o,
    input  wire  [31:0]                  dram_rdata_i,
    input  wire                          dram_ack_i,
    input  wire                          dram_busy_i
);

    import csr_cmd_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SPECIAL,
        ST_CSR_ADDR,
        ST_CSR_DATA,
        ST_CSR_RESP,
        ST_PROM_MID,
        ST_PROM_LOW,
        ST_PROM_DATA,
        ST_PROM_WR,
        ST_SP_ADDR,
        ST_SP_REQ,
        ST_SP_ACK,
        ST_SP_DATA,
        ST_SP_WR
    } state_t;

    state_t                  state_q;
    cmd_byte_t               cmd;
    logic                    cmd_we_q;
    logic [4:0]              rep_q;    // Words or bytes left in this command
    logic [1:0]              byte_q;
    logic [19:0]             addr_q;
    logic [`CSR_DRAM_AW-1:0] sp_addr_q;
    logic [31:0]             wdata_q;
    logic [31:0]             rdata_q;

    assign cmd = cmd_byte_t'(rx_data_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            tx_load_o <= 1'b0;
            cmd_we_q  <= 1'b0;
            rep_q     <= 5'd0;
            byte_q    <= 2'd0;
        end else if (ss_idle_i) begin
            state_q   <= ST_IDLE;
            tx_load_o <= 1'b0;
        end else begin
            tx_load_o <= rx_pop_i && state_q != ST_CSR_DATA;
            case (state_q)
                ST_IDLE: begin
                    if (rx_pop_i) begin
                        cmd_we_q <= cmd.we;
                        rep_q    <= rep_count(cmd.rep);
                        addr_q   <= {16'h0000, cmd.addr_hi};
                        byte_q   <= 2'd0;
                        if (cmd.rep == REP_0 && cmd.addr_hi == 4'hF) begin
                            tx_data_o <= RSP_SPECIAL;
                            state_q   <= ST_SPECIAL;
                        end else if (cmd.rep == REP_0) begin
                            tx_data_o <= RSP_NOP;
                        end else if (cmd.prom) begin
                            tx_data_o <= RSP_PROM;
                            state_q   <= ST_PROM_MID;
                        end else begin
                            tx_data_o <= RSP_CSR;
                            state_q   <= ST_CSR_ADDR;
                        end
                    end
                end
                ST_SPECIAL: begin
                    if (rx_pop_i) begin
                        cmd_we_q  <= cmd.we;
                        rep_q     <= rep_count(cmd.rep);
                        byte_q    <= 2'd3;
                        tx_data_o <= RSP_DRAM_CMD;
                        state_q   <= ST_SP_ADDR;
                    end
                end
                ST_CSR_ADDR: begin
                    if (rx_pop_i) begin
                        addr_q    <= {addr_q[11:0], rx_data_i};
                        tx_data_o <= RSP_CSR_ADDR;
                        state_q   <= ST_CSR_DATA;
                    end
                end
                ST_CSR_DATA: begin
                    if (rx_pop_i) begin
                        state_q <= ST_CSR_RESP; // Write lands now, read back next cycle
                    end
                end
                ST_CSR_RESP: begin
                    tx_data_o <= reg_rdata_i;
                    tx_load_o <= 1'b1;
                    addr_q    <= addr_q + 20'd1;
                    rep_q     <= rep_q - 5'd1;
                    state_q   <= (rep_q <= 5'd1) ? ST_IDLE : ST_CSR_DATA;
                end
                ST_PROM_MID: begin
                    if (rx_pop_i) begin
                        addr_q    <= {addr_q[11:0], rx_data_i};
                        tx_data_o <= RSP_PROM_MID;
                        state_q   <= ST_PROM_LOW;
                    end
                end
                ST_PROM_LOW: begin
                    if (rx_pop_i) begin
                        addr_q    <= {addr_q[11:0], rx_data_i};
                        tx_data_o <= RSP_PROM_LOW;
                        state_q   <= ST_PROM_DATA;
                    end
                end
                ST_PROM_DATA: begin
                    if (rx_pop_i) begin
                        wdata_q   <= {wdata_q[23:0], rx_data_i};
                        tx_data_o <= RSP_PROM_DATA_BASE | {6'd0, byte_q};
                        byte_q    <= byte_q + 2'd1;
                        if (byte_q == 2'd3) begin
                            state_q <= ST_PROM_WR;
                        end
                    end
                end
                ST_PROM_WR: begin
                    addr_q  <= addr_q + 20'd1;
                    rep_q   <= rep_q - 5'd1;
                    state_q <= (rep_q <= 5'd1) ? ST_IDLE : ST_PROM_DATA;
                end
                ST_SP_ADDR: begin
                    if (rx_pop_i) begin
                        sp_addr_q <= {sp_addr_q[`CSR_DRAM_AW-9:0], rx_data_i};
                        tx_data_o <= RSP_DRAM_ADDR_BASE | {6'd0, byte_q};
                        byte_q    <= byte_q - 2'd1; // Wraps to 3 for the data bytes
                        if (byte_q == 2'd0) begin
                            state_q <= ST_SP_REQ;
                        end
                    end
                end
                ST_SP_REQ: begin
                    if (!dram_busy_i) begin
                        state_q <= ST_SP_ACK;
                    end
                end
                ST_SP_ACK: begin
                    if (dram_ack_i) begin
                        rdata_q <= dram_rdata_i;
                        state_q <= ST_SP_DATA;
                    end
                end
                ST_SP_DATA: begin
                    if (rx_pop_i) begin
                        wdata_q   <= {wdata_q[23:0], rx_data_i};
                        tx_data_o <= rdata_q[8*byte_q +: 8]; // MSB first
                        byte_q    <= byte_q - 2'd1;
                        if (byte_q == 2'd0) begin
                            state_q <= ST_SP_WR;
                        end
                    end
                end
                ST_SP_WR: begin
                    sp_addr_q <= sp_addr_q + 1'b1;
                    rep_q     <= rep_q - 5'd1;
                    state_q   <= (rep_q <= 5'd1) ? ST_IDLE : ST_SP_REQ;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign reg_addr_o   = addr_q[11:0];
    assign reg_we_o     = state_q == ST_CSR_DATA && rx_pop_i && cmd_we_q;
    assign prom_addr_o  = addr_q;
    assign prom_wdata_o = wdata_q;
    assign prom_we_o    = state_q == ST_PROM_WR;
    assign dram_addr_o  = sp_addr_q;
    assign dram_wdata_o = wdata_q;
    assign dram_pop_o   = state_q == ST_SP_REQ && !dram_busy_i;
    assign dram_we_o    = state_q == ST_SP_WR && cmd_we_q;

endmodule

`default_nettype wire

/* source/csr_spi.sv */
`timescale 1ns/10ps
`include "csr_defines.svh"
`default_nettype none

module csr_spi (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        sck_i,
    input  wire                                        mosi_i,
    input  wire                                        ss_i,
    output wire                                        miso_o,
    output wire  [`CSR_NUM_CH*32-1:0]                  vol_o,
    output wire                                        nkmd_rst_o,
    input  wire  [`CSR_DBG_BYTES*8-1:0]                dbgout_i,
    output wire  [`CSR_DBG_BYTES*8-1:0]                dbgin_o,
    input  wire  [`CSR_NUM_SPDIF_IN*`CSR_NUM_RATE-1:0] rate_i,
    output wire  [19:0]                                prom_addr_o,
    output wire  [31:0]                                prom_wdata_o,
    output wire                                        prom_we_o,
    output wire  [`CSR_DRAM_AW-1:0]                    dram_addr_o,
    output wire  [31:0]                                dram_wdata_o,
    output wire                                        dram_pop_o,
    output wire                                        dram_we_o,
    input  wire  [31:0]                                dram_rdata_i,
    input  wire                                        dram_ack_i,
    input  wire                                        dram_busy_i
);

    import csr_map_pkg::*;

    wire [7:0] rx_data;
    wire       rx_pop;
    wire       ss_idle;
    wire [7:0] tx_data;
    wire       tx_load;
    csr_addr_t reg_addr;
    wire       reg_we;
    wire [7:0] reg_rdata;

    spi_trx i_spi_trx (
        .clk       (clk),
        .rst       (rst),
        .sck_i     (sck_i),
        .mosi_i    (mosi_i),
        .ss_i      (ss_i),
        .miso_o    (miso_o),
        .rx_data_o (rx_data),
        .rx_pop_o  (rx_pop),
        .ss_idle_o (ss_idle),
        .tx_data_i (tx_data),
        .tx_load_i (tx_load)
    );

    csr_sequencer i_csr_sequencer (
        .clk          (clk),
        .rst          (rst),
        .rx_data_i    (rx_data),
        .rx_pop_i     (rx_pop),
        .ss_idle_i    (ss_idle),
        .tx_data_o    (tx_data),
        .tx_load_o    (tx_load),
        .reg_addr_o   (reg_addr),
        .reg_we_o     (reg_we),
        .reg_rdata_i  (reg_rdata),
        .prom_addr_o  (prom_addr_o),
        .prom_wdata_o (prom_wdata_o),
        .prom_we_o    (prom_we_o),
        .dram_addr_o  (dram_addr_o),
        .dram_wdata_o (dram_wdata_o),
        .dram_pop_o   (dram_pop_o),
        .dram_we_o    (dram_we_o),
        .dram_rdata_i (dram_rdata_i),
        .dram_ack_i   (dram_ack_i),
        .dram_busy_i  (dram_busy_i)
    );

    csr_regs i_csr_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_addr_i  (reg_addr),
        .reg_we_i    (reg_we),
        .reg_wdata_i (rx_data), // Data byte comes straight from the receiver
        .dbgout_i    (dbgout_i),
        .rate_i      (rate_i),
        .reg_rdata_o (reg_rdata),
        .vol_o       (vol_o),
        .nkmd_rst_o  (nkmd_rst_o),
        .dbgin_o     (dbgin_o)
    );

endmodule

`default_nettype wire

/* source/spi_trx.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_trx (
    input  wire       clk,
    input  wire       rst,
    input  wire       sck_i,
    input  wire       mosi_i,
    input  wire       ss_i,
    output wire       miso_o,
    output wire [7:0] rx_data_o,
    output wire       rx_pop_o,
    output wire       ss_idle_o,
    input  wire [7:0] tx_data_i,
    input  wire       tx_load_i
);

    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic       sck_fall;
    logic       byte_done;
    logic [2:0] bit_cnt;
    logic [2:0] pop_pipe;
    logic [7:0] rx_shift;
    logic [7:0] tx_hold;
    logic [7:0] tx_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync  <= 2'b00;
            mosi_sync <= 2'b00;
            ss_sync   <= 2'b11;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
            ss_sync   <= {ss_sync[0], ss_i};
            sck_prev  <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_prev & ~ss_sync[1];
    assign sck_fall  = ~sck_sync[1] & sck_prev & ~ss_sync[1];
    assign byte_done = sck_rise && bit_cnt == 3'd7;

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= 3'd0;
            pop_pipe <= 3'b000;
            tx_hold  <= 8'h00;
            tx_shift <= 8'h00;
        end else begin
            pop_pipe <= {pop_pipe[1:0], byte_done}; // Pop lands 3 cycles after edge
            if (ss_sync[1]) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            if (tx_load_i) begin
                tx_hold  <= tx_data_i;
                tx_shift <= tx_data_i;
            end else if (ss_sync[1] || (sck_fall && bit_cnt == 3'd0)) begin
                tx_shift <= tx_hold; // Byte boundary, resend if nothing new queued
            end else if (sck_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
        end
    end

    assign miso_o    = tx_shift[7];
    assign rx_data_o = rx_shift;
    assign rx_pop_o  = pop_pipe[2];
    assign ss_idle_o = ss_sync[1];

endmodule

`default_nettype wire

/* testbench/tb_csr_spi_tasks.svh */
task automatic check_value(input string name, input logic [127:0] exp,
                           input logic [127:0] got);
    assert (got === exp) else begin
        $display("error %s expected 0x%0h got 0x%0h", name, exp, got);
        $display("sim failed");
        $fatal(1);
    end
endtask

function automatic logic [7:0] pack_cmd(input logic we, input logic [1:0] rep,
                                        input logic prom, input logic [3:0] hi);
    return {we, rep, prom, hi};  // MSB down: we, repeat, target, nibble
endfunction

// SPI mode 0 master, 4 clocks per half period, then a 20 clock gap
task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    int i;
    rx = 8'h00;
    for (i = 0; i < nbits; i++) begin
        @(posedge clk);
        sck  <= 1'b0;
        mosi <= tx[7-i];
        repeat (4) @(posedge clk);
        rx[7-i] = miso;
        sck <= 1'b1;
        repeat (3) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;
    repeat (20) @(posedge clk);
endtask

// Sends a byte and checks the answer to the byte before it
task automatic send_check(input logic [7:0] tx, input logic [7:0] exp);
    logic [7:0] rx;
    shift_bits(tx, 8, rx);
    check_value("miso_o", exp, rx);
endtask

task automatic test_nop_pipeline();
    send_check(pack_cmd(0, 2'd0, 0, 4'h0), 8'h00);
    send_check(pack_cmd(0, 2'd0, 0, 4'h0), RSP_NOP);
endtask

task automatic test_reg_write_read();
    csr_addr_t  a;
    logic [7:0] d [4];
    logic [7:0] wr;
    a = VOL_BASE + 12'd8;  // Channel 2
    send_check(pack_cmd(1, 2'd2, 0, a[11:8]), RSP_NOP);
    send_check(a[7:0], RSP_CSR);
    for (int i = 0; i < 4; i++) begin
        d[i] = 8'($random(seed));
        send_check(d[i], (i == 0) ? RSP_CSR_ADDR : d[i-1]);
    end
    send_check(8'h00, d[3]);
    check_value("vol_o", {d[0], d[1], d[2], d[3]}, vol[32*2 +: 32]);
    send_check(pack_cmd(0, 2'd2, 0, a[11:8]), RSP_NOP);
    send_check(a[7:0], RSP_CSR);
    for (int i = 0; i < 4; i++) begin
        send_check(8'h00, (i == 0) ? RSP_CSR_ADDR : d[i-1]);
    end
    send_check(8'h00, d[3]);
    wr = 8'($random(seed)) | 8'h01;
    send_check(pack_cmd(1, 2'd1, 0, DBGOUT_BASE[11:8]), RSP_NOP);
    send_check(DBGOUT_BASE[7:0], RSP_CSR);
    send_check(wr, RSP_CSR_ADDR);
    send_check(8'h00, dbgout[7:0]);  // Read-only byte unchanged
    check_value("vol_o", {d[0], d[1], d[2], d[3]}, vol[32*2 +: 32]);
    check_value("dbgin_o", 128'h0, dbgin);
    send_check(pack_cmd(1, 2'd1, 0, NKMD_RST_ADDR[11:8]), RSP_NOP);
    send_check(NKMD_RST_ADDR[7:0], RSP_CSR);
    send_check(8'h01, RSP_CSR_ADDR);
    send_check(8'h00, 8'h01);
    check_value("nkmd_rst_o", 1'b1, nkmd_rst);
endtask

task automatic test_read_only();
    csr_addr_t  base;
    logic [7:0] prev;
    logic [7:0] exp;
    @(posedge clk);
    dbgout <= {$random(seed), $random(seed), $random(seed), $random(seed)};
    rate   <= 15'($random(seed));
    repeat (4) @(posedge clk);
    for (int w = 0; w < 2; w++) begin
        base = (w == 0) ? DBGOUT_BASE : RATE_BASE;
        send_check(pack_cmd(0, 2'd3, 0, base[11:8]), RSP_NOP);
        send_check(base[7:0], RSP_CSR);
        prev = RSP_CSR_ADDR;
        for (int i = 0; i < 16; i++) begin
            send_check(8'h00, prev);
            if (w == 0) begin
                exp = dbgout[8*i +: 8];
            end else if (i < `CSR_NUM_SPDIF_IN) begin
                exp = {3'b000, rate[`CSR_NUM_RATE*i +: `CSR_NUM_RATE]};
            end else begin
                exp = 8'h00;  // Unmapped tail
            end
            prev = exp;
        end
        send_check(8'h00, prev);
    end
endtask

task automatic test_prom_stream();
    logic [19:0] a;
    logic [31:0] w [4];
    logic [7:0]  prev;
    int          n0;
    a  = 20'($random(seed));
    n0 = prom_addr_log.size();
    send_check(pack_cmd(1, 2'd2, 1, a[19:16]), RSP_NOP);
    send_check(a[15:8], RSP_PROM);
    send_check(a[7:0], RSP_PROM_MID);
    prev = RSP_PROM_LOW;
    for (int k = 0; k < 4; k++) begin
        w[k] = $random(seed);
        for (int j = 0; j < 4; j++) begin
            send_check(w[k][31-8*j -: 8], prev);
            prev = RSP_PROM_DATA_BASE | 8'(j);
        end
    end
    send_check(8'h00, prev);
    check_value("prom_we_o count", 4, prom_addr_log.size() - n0);
    for (int k = 0; k < 4; k++) begin
        check_value("prom_addr_o", a + 20'(k), prom_addr_log[n0+k]);
        check_value("prom_wdata_o", w[k], prom_data_log[n0+k]);
    end
endtask

task automatic dram_sequence(input logic we, input logic [1:0] rep, input int words,
                             input logic [27:0] addr, input logic [31:0] wdata);
    logic [31:0] ab;
    logic [7:0]  prev;
    logic [31:0] old;
    ab = {4'h0, addr};
    send_check(pack_cmd(0, 2'd0, 0, 4'hF), RSP_NOP);
    send_check(pack_cmd(we, rep, 0, 4'h0), RSP_SPECIAL);
    prev = RSP_DRAM_CMD;
    for (int j = 0; j < 4; j++) begin
        send_check(ab[31-8*j -: 8], prev);
        prev = RSP_DRAM_ADDR_BASE | 8'(3 - j);
    end
    for (int k = 0; k < words; k++) begin
        old = dram_mem[8'(addr[7:0] + k)];
        for (int j = 0; j < 4; j++) begin
            send_check(we ? wdata[31-8*j -: 8] : 8'h00, prev);
            prev = old[31-8*j -: 8];
        end
    end
    send_check(8'h00, prev);
endtask

task automatic test_dram_poke_peek();
    logic [27:0] a;
    logic [31:0] w;
    a = {20'($random(seed)), 8'(($random(seed) & 32'h7F) + 16)};
    w = $random(seed);
    dram_sequence(1'b1, 2'd1, 1, a, w);
    check_value("dram_mem", w, dram_mem[a[7:0]]);
    check_value("dram_addr_o", a, dram_we_addr);
    dram_sequence(1'b0, 2'd2, 4, a, 32'h0);
endtask

task automatic test_ss_abort();
    logic [7:0] rx;
    int         n0;
    n0 = prom_addr_log.size();
    send_check(pack_cmd(1, 2'd1, 1, 4'h3), RSP_NOP);
    send_check(8'($random(seed)), RSP_PROM);
    shift_bits(8'($random(seed)), 3, rx);  // Low address byte cut short
    @(posedge clk);
    ss <= 1'b1;
    repeat (10) @(posedge clk);
    ss <= 1'b0;
    repeat (10) @(posedge clk);
    send_check(pack_cmd(0, 2'd0, 0, 4'h0), RSP_PROM_MID);
    send_check(pack_cmd(0, 2'd0, 0, 4'h0), RSP_NOP);
    // A missed abort would turn these into a full ROM word
    repeat (4) begin
        send_check(pack_cmd(0, 2'd0, 0, 4'h0), RSP_NOP);
    end
    check_value("prom_we_o count", 0, prom_addr_log.size() - n0);
endtask

/* testbench/tb_csr_spi.sv */
`timescale 1ns/10ps
`include "csr_defines.svh"
`default_nettype none

module tb_csr_spi;

    import csr_cmd_pkg::*;
    import csr_map_pkg::*;

    localparam int CLK_NS     = 100;
    localparam int BYTE_CLKS  = 8 * 8 + 21;  // Eight bits plus idle gap
    localparam int TEST_BYTES = 125;          // All bytes sent by the test list
    localparam int WATCHDOG_NS = 2 * TEST_BYTES * BYTE_CLKS * CLK_NS + 20 * CLK_NS;

    logic                                        clk;
    logic                                        rst;
    logic                                        sck;
    logic                                        mosi;
    logic                                        ss;
    wire                                         miso;
    wire  [`CSR_NUM_CH*32-1:0]                   vol;
    wire                                         nkmd_rst;
    logic [`CSR_DBG_BYTES*8-1:0]                 dbgout;
    wire  [`CSR_DBG_BYTES*8-1:0]                 dbgin;
    logic [`CSR_NUM_SPDIF_IN*`CSR_NUM_RATE-1:0]  rate;
    wire  [19:0]                                 prom_addr;
    wire  [31:0]                                 prom_wdata;
    wire                                         prom_we;
    wire  [`CSR_DRAM_AW-1:0]                     dram_addr;
    wire  [31:0]                                 dram_wdata;
    wire                                         dram_pop;
    wire                                         dram_we;
    logic [31:0]                                 dram_rdata;
    logic                                        dram_ack;
    logic                                        dram_busy;

    logic [31:0]             dram_mem [256];
    logic [1:0]              busy_cnt;
    logic [1:0]              ack_cnt;
    logic [7:0]              read_idx;
    logic [`CSR_DRAM_AW-1:0] dram_we_addr;
    logic [19:0]             prom_addr_log [$];
    logic [31:0]             prom_data_log [$];
    integer                  seed = 15226;

    csr_spi i_csr_spi (
        .clk          (clk),
        .rst          (rst),
        .sck_i        (sck),
        .mosi_i       (mosi),
        .ss_i         (ss),
        .miso_o       (miso),
        .vol_o        (vol),
        .nkmd_rst_o   (nkmd_rst),
        .dbgout_i     (dbgout),
        .dbgin_o      (dbgin),
        .rate_i       (rate),
        .prom_addr_o  (prom_addr),
        .prom_wdata_o (prom_wdata),
        .prom_we_o    (prom_we),
        .dram_addr_o  (dram_addr),
        .dram_wdata_o (dram_wdata),
        .dram_pop_o   (dram_pop),
        .dram_we_o    (dram_we),
        .dram_rdata_i (dram_rdata),
        .dram_ack_i   (dram_ack),
        .dram_busy_i  (dram_busy)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // DRAM model: busy high 3 of every 4 cycles, ack 2 cycles after pop
    always @(posedge clk) begin
        dram_ack <= 1'b0;
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dram_mem[i] <= {8'hD0 ^ i[7:0], i[7:0], ~i[7:0], i[7:0] + 8'h33};
            end
            busy_cnt  <= 2'd0;
            ack_cnt   <= 2'd0;
            dram_busy <= 1'b1;
        end else begin
            busy_cnt  <= busy_cnt + 2'd1;
            dram_busy <= busy_cnt != 2'd3;
            if (dram_pop) begin
                ack_cnt  <= 2'd2;
                read_idx <= dram_addr[7:0];
            end else if (ack_cnt != 2'd0) begin
                ack_cnt <= ack_cnt - 2'd1;
            end
            if (ack_cnt == 2'd1) begin
                dram_ack   <= 1'b1;
                dram_rdata <= dram_mem[read_idx];
            end
            if (dram_we) begin
                dram_mem[dram_addr[7:0]] <= dram_wdata;
                dram_we_addr             <= dram_addr;
            end
            assert (!(dram_pop && dram_busy)) else begin
                $display("dram_pop_o was asserted while dram_busy_i was high");
                $display("sim failed");
                $fatal(1);
            end
        end
    end

    always @(posedge clk) begin
        if (prom_we) begin
            prom_addr_log.push_back(prom_addr);
            prom_data_log.push_back(prom_wdata);
        end
    end

    `include "tb_csr_spi_tasks.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        sck        = 1'b0;
        mosi       = 1'b0;
        ss         = 1'b1;
        dbgout     = '0;
        rate       = '0;
        dram_rdata = 32'h0;
        dram_ack   = 1'b0;
        dram_busy  = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        ss <= 1'b0;
        repeat (4) @(posedge clk);
        test_nop_pipeline();
        test_reg_write_read();
        test_read_only();
        test_prom_stream();
        test_dram_poke_peek();
        test_ss_abort();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
